// ==== common/rv_pkg.sv ====
// rv_pkg: shared widths, opcodes, funct codes, alu op indices and the instruction word union.
`default_nettype none

package rv_pkg;

  localparam int XLEN     = 64; // register and data width.
  localparam int INST_W   = 32; // instruction width.
  localparam int REG_ID_W = 5;
  localparam int ALU_OP_W = 10; // one bit per alu operation.

  // bit positions inside the one-hot alu operation.
  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_LT  = 2;
  localparam int ALU_LTU = 3;
  localparam int ALU_AND = 4;
  localparam int ALU_OR  = 5;
  localparam int ALU_XOR = 6;
  localparam int ALU_SLL = 7;
  localparam int ALU_SRL = 8;
  localparam int ALU_SRA = 9;

  // major opcodes.
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD   = 3'b000; // also sub, jalr and ebreak.
  localparam logic [2:0] F3_SLL   = 3'b001;
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_SLTU  = 3'b011;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_SR    = 3'b101; // srl and sra share it.
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_DWORD = 3'b011; // ld / sd width.

  localparam logic [6:0]  F7_BASE    = 7'b0000000;
  localparam logic [6:0]  F7_ALT     = 7'b0100000; // sub and sra.
  localparam logic [11:0] F12_EBREAK = 12'h001;

  // sequencer states.
  localparam int         ST_W        = 3;
  localparam logic [2:0] ST_FETCH    = 3'd0;
  localparam logic [2:0] ST_FETCH_REL = 3'd1;
  localparam logic [2:0] ST_EXEC     = 3'd2;
  localparam logic [2:0] ST_MEM      = 3'd3;
  localparam logic [2:0] ST_MEM_REL  = 3'd4;
  localparam logic [2:0] ST_WB       = 3'd5;
  localparam logic [2:0] ST_HALT     = 3'd6;

  // one 32 bit word seen through each base format.
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
      logic [4:0] rd;   logic [6:0] opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3;   logic [4:0] imm_4_0; logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
    } u_fmt;
    struct packed {
      logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
      logic [4:0] rd; logic [6:0] opcode;
    } j_fmt;
  } inst_u;

endpackage

`default_nettype wire

// ==== hw/decoder/decoder.sv ====
// decoder splits an instruction word into register indices, immediate, alu op and control flags.
`timescale 1ns/100ps
`default_nettype none

module decoder
  import rv_pkg::*;
(
  input  inst_u                inst,
  output logic [REG_ID_W-1:0]  rd,
  output logic [REG_ID_W-1:0]  rs1,
  output logic [REG_ID_W-1:0]  rs2,
  output logic [XLEN-1:0]      imm,
  output logic                 need_imm,  // operand b comes from imm, not rs2.
  output logic [ALU_OP_W-1:0]  alu_op,
  output logic                 is_ebreak,
  output logic                 is_auipc,
  output logic                 is_lui,
  output logic                 is_jal,
  output logic                 is_jalr,
  output logic                 is_load,
  output logic                 is_store,
  output logic                 reg_wen,
  output logic                 illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       op_imm, op_op, op_lui, op_auipc, op_jal, op_jalr, op_load, op_store, op_system;
  logic       addi, slti, sltiu, andi, ori, xori, slli, srli, srai;
  logic       add_i, sub_i, slt_i, sltu_i, and_i, or_i, xor_i, sll_i, srl_i, sra_i;
  logic       jal_i, jalr_i, ld_i, sd_i, ebreak_i;
  logic       type_i, type_s, type_u, type_j;
  logic [XLEN-1:0] imm_i, imm_s, imm_u, imm_j;

  assign opcode = inst.r_fmt.opcode; // same place in every format.
  assign funct3 = inst.r_fmt.funct3;
  assign funct7 = inst.r_fmt.funct7;

  assign op_imm    = (opcode == OP_IMM);
  assign op_op     = (opcode == OP_OP);
  assign op_lui    = (opcode == OP_LUI);
  assign op_auipc  = (opcode == OP_AUIPC);
  assign op_jal    = (opcode == OP_JAL);
  assign op_jalr   = (opcode == OP_JALR);
  assign op_load   = (opcode == OP_LOAD);
  assign op_store  = (opcode == OP_STORE);
  assign op_system = (opcode == OP_SYSTEM);

  // register-immediate; rv64 shifts keep a 6 bit shamt, so only imm[11:6] is funct.
  assign addi  = op_imm & (funct3 == F3_ADD);
  assign slti  = op_imm & (funct3 == F3_SLT);
  assign sltiu = op_imm & (funct3 == F3_SLTU);
  assign xori  = op_imm & (funct3 == F3_XOR);
  assign ori   = op_imm & (funct3 == F3_OR);
  assign andi  = op_imm & (funct3 == F3_AND);
  assign slli  = op_imm & (funct3 == F3_SLL) & (inst.i_fmt.imm[11:6] == F7_BASE[6:1]);
  assign srli  = op_imm & (funct3 == F3_SR)  & (inst.i_fmt.imm[11:6] == F7_BASE[6:1]);
  assign srai  = op_imm & (funct3 == F3_SR)  & (inst.i_fmt.imm[11:6] == F7_ALT[6:1]);

  // register-register.
  assign add_i  = op_op & (funct3 == F3_ADD)  & (funct7 == F7_BASE);
  assign sub_i  = op_op & (funct3 == F3_ADD)  & (funct7 == F7_ALT);
  assign sll_i  = op_op & (funct3 == F3_SLL)  & (funct7 == F7_BASE);
  assign slt_i  = op_op & (funct3 == F3_SLT)  & (funct7 == F7_BASE);
  assign sltu_i = op_op & (funct3 == F3_SLTU) & (funct7 == F7_BASE);
  assign xor_i  = op_op & (funct3 == F3_XOR)  & (funct7 == F7_BASE);
  assign srl_i  = op_op & (funct3 == F3_SR)   & (funct7 == F7_BASE);
  assign sra_i  = op_op & (funct3 == F3_SR)   & (funct7 == F7_ALT);
  assign or_i   = op_op & (funct3 == F3_OR)   & (funct7 == F7_BASE);
  assign and_i  = op_op & (funct3 == F3_AND)  & (funct7 == F7_BASE);

  assign jal_i    = op_jal;
  assign jalr_i   = op_jalr & (funct3 == F3_ADD);
  assign ld_i     = op_load & (funct3 == F3_DWORD); // doubleword only.
  assign sd_i     = op_store & (funct3 == F3_DWORD);
  assign ebreak_i = op_system & (funct3 == F3_ADD) & (inst.i_fmt.imm == F12_EBREAK);

  // immediates are all sign extended to xlen.
  assign imm_i = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{(XLEN-12){inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  assign imm_u = {{(XLEN-32){inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12, 12'b0};
  assign imm_j = {{(XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  assign type_i = op_imm | ld_i | jalr_i;
  assign type_s = sd_i;
  assign type_u = op_lui | op_auipc;
  assign type_j = jal_i;

  assign imm = ({XLEN{type_i}} & imm_i) | ({XLEN{type_s}} & imm_s) |
               ({XLEN{type_u}} & imm_u) | ({XLEN{type_j}} & imm_j);

  assign rd  = inst.r_fmt.rd;
  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;

  // address and target math all go through the adder.
  assign alu_op[ALU_ADD] = addi | add_i | op_auipc | ld_i | sd_i | jalr_i | jal_i;
  assign alu_op[ALU_SUB] = sub_i;
  assign alu_op[ALU_LT]  = slti | slt_i;
  assign alu_op[ALU_LTU] = sltiu | sltu_i;
  assign alu_op[ALU_AND] = andi | and_i;
  assign alu_op[ALU_OR]  = ori | or_i;
  assign alu_op[ALU_XOR] = xori | xor_i;
  assign alu_op[ALU_SLL] = slli | sll_i;
  assign alu_op[ALU_SRL] = srli | srl_i;
  assign alu_op[ALU_SRA] = srai | sra_i;

  assign need_imm  = op_imm | op_lui | op_auipc | ld_i | sd_i | jalr_i | jal_i;
  assign is_ebreak = ebreak_i;
  assign is_auipc  = op_auipc;
  assign is_lui    = op_lui;
  assign is_jal    = jal_i;
  assign is_jalr   = jalr_i;
  assign is_load   = ld_i;
  assign is_store  = sd_i;
  assign reg_wen   = addi | slti | sltiu | andi | ori | xori | slli | srli | srai |
                     add_i | sub_i | slt_i | sltu_i | and_i | or_i | xor_i |
                     sll_i | srl_i | sra_i | op_lui | op_auipc | jal_i | jalr_i | ld_i;

  // anything not named above halts the core.
  assign illegal = ~(reg_wen | sd_i | ebreak_i);

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
// regfile: 31 writable 64 bit registers plus hard-wired zero, two read and one write port.
`timescale 1ns/100ps
`default_nettype none

module regfile
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [REG_ID_W-1:0] rs1,
  input  logic [REG_ID_W-1:0] rs2,
  output logic [XLEN-1:0]     rs1_data,
  output logic [XLEN-1:0]     rs2_data,
  input  logic                wen,
  input  logic [REG_ID_W-1:0] rd,
  input  logic [XLEN-1:0]     wdata
);

  logic [XLEN-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0; // known start for every test.
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata; // writes to x0 dropped.
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
// alu: 64 bit add, sub, compare, logic and shift unit driven by a one-hot op.
`timescale 1ns/100ps
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  logic [ALU_OP_W-1:0] alu_op,
  input  logic [XLEN-1:0]     src_a,
  input  logic [XLEN-1:0]     src_b,
  output logic [XLEN-1:0]     result
);

  logic [5:0]      shamt;
  logic [XLEN-1:0] sum, diff, lt, ltu, sll_r, srl_r, sra_r;

  assign shamt = src_b[5:0];                  // rv64 shifts use six bits.
  assign sum   = src_a + src_b;
  assign diff  = src_a - src_b;
  assign lt    = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
  assign ltu   = {{(XLEN-1){1'b0}}, src_a < src_b};
  assign sll_r = src_a << shamt;
  assign srl_r = src_a >> shamt;
  assign sra_r = $signed(src_a) >>> shamt;    // sign fills from the top.

  // op is one-hot, so an and-or mux is enough.
  assign result = ({XLEN{alu_op[ALU_ADD]}} & sum)            |
                  ({XLEN{alu_op[ALU_SUB]}} & diff)           |
                  ({XLEN{alu_op[ALU_LT]}}  & lt)             |
                  ({XLEN{alu_op[ALU_LTU]}} & ltu)            |
                  ({XLEN{alu_op[ALU_AND]}} & (src_a & src_b)) |
                  ({XLEN{alu_op[ALU_OR]}}  & (src_a | src_b)) |
                  ({XLEN{alu_op[ALU_XOR]}} & (src_a ^ src_b)) |
                  ({XLEN{alu_op[ALU_SLL]}} & sll_r)          |
                  ({XLEN{alu_op[ALU_SRL]}} & srl_r)          |
                  ({XLEN{alu_op[ALU_SRA]}} & sra_r);

endmodule

`default_nettype wire

// ==== hw/core_fsm.sv ====
// core_fsm: pc, instruction register, fetch/execute/memory sequencing and four-phase bus master.
`timescale 1ns/100ps
`default_nettype none

module core_fsm
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  output logic            mem_req,
  output logic            mem_we,
  output logic [XLEN-1:0] mem_addr,
  output logic [XLEN-1:0] mem_wdata,
  input  logic            mem_ack,
  input  logic [XLEN-1:0] mem_rdata,
  output inst_u           inst,
  input  logic            need_imm,
  input  logic [XLEN-1:0] imm,
  input  logic            is_ebreak,
  input  logic            is_auipc,
  input  logic            is_lui,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_load,
  input  logic            is_store,
  input  logic            reg_wen,
  input  logic            illegal,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output logic [XLEN-1:0] alu_a,
  output logic [XLEN-1:0] alu_b,
  input  logic [XLEN-1:0] alu_result,
  output logic            wb_en,
  output logic [XLEN-1:0] wb_data,
  output logic            halted,
  output logic            illegal_halt
);

  logic [ST_W-1:0] state;
  logic [XLEN-1:0] pc, pc_plus4, pc_next;
  logic [XLEN-1:0] ld_data;   // load word held for the writeback cycle.
  logic            stop;

  assign pc_plus4 = pc + 64'd4;
  assign stop     = is_ebreak | illegal;

  // auipc and jal add to the pc.
  assign alu_a = (is_auipc | is_jal) ? pc : rs1_data;
  assign alu_b = need_imm ? imm : rs2_data;

  assign pc_next = is_jal  ? alu_result :
                   is_jalr ? {alu_result[XLEN-1:1], 1'b0} :
                   pc_plus4;

  // execute writes everything except loads, which wait for the bus.
  assign wb_en   = ((state == ST_EXEC) & reg_wen & ~is_load) | (state == ST_WB);
  assign wb_data = (state == ST_WB)     ? ld_data :
                   is_lui               ? imm :
                   (is_jal | is_jalr)   ? pc_plus4 :
                   alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ST_FETCH;
      pc           <= '0;
      mem_req      <= 1'b0;
      mem_we       <= 1'b0;
      halted       <= 1'b0;
      illegal_halt <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (!mem_req && !mem_ack) begin
            mem_req <= 1'b1;                   // previous ack is low, start fetch.
            mem_we  <= 1'b0;
          end else if (mem_req && mem_ack) begin
            mem_req <= 1'b0;
            state   <= ST_FETCH_REL;
          end
        end
        ST_FETCH_REL: if (!mem_ack) state <= ST_EXEC;
        ST_EXEC: begin
          if (stop) begin
            halted       <= 1'b1;              // sticky until reset.
            illegal_halt <= illegal;
            state        <= ST_HALT;
          end else begin
            pc <= pc_next;
            if (is_load || is_store) begin
              mem_req <= 1'b1;                 // second handshake right away.
              mem_we  <= is_store;
              state   <= ST_MEM;
            end else begin
              state <= ST_FETCH;
            end
          end
        end
        ST_MEM: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= ST_MEM_REL;
          end
        end
        ST_MEM_REL: begin
          if (!mem_ack) begin
            mem_we <= 1'b0;
            state  <= is_load ? ST_WB : ST_FETCH;
          end
        end
        ST_WB:   state <= ST_FETCH;
        ST_HALT: state <= ST_HALT;            // no more requests.
        default: state <= ST_HALT;
      endcase
    end
  end

  // bus payload and captured data.
  always_ff @(posedge clk) begin
    if (state == ST_FETCH && !mem_req) mem_addr <= {pc[XLEN-1:3], 3'b000};
    if (state == ST_FETCH && mem_req && mem_ack) begin
      inst <= pc[2] ? mem_rdata[2*INST_W-1:INST_W] : mem_rdata[INST_W-1:0]; // word by pc[2].
    end
    if (state == ST_EXEC) mem_addr <= {alu_result[XLEN-1:3], 3'b000};
    if (state == ST_EXEC && is_store) mem_wdata <= rs2_data;
    if (state == ST_MEM && mem_ack) ld_data <= mem_rdata;
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
// rv_core: multicycle rv64i core, sequencer, decoder, register file and alu on one memory bus.
`timescale 1ns/100ps
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  output logic            mem_req,
  output logic            mem_we,
  output logic [XLEN-1:0] mem_addr,
  output logic [XLEN-1:0] mem_wdata,
  input  logic            mem_ack,
  input  logic [XLEN-1:0] mem_rdata,
  output logic            halted,
  output logic            illegal
);

  inst_u               inst;
  logic [REG_ID_W-1:0] rd, rs1, rs2;
  logic [XLEN-1:0]     imm, rs1_data, rs2_data, alu_a, alu_b, alu_result, wb_data;
  logic [ALU_OP_W-1:0] alu_op;
  logic                need_imm, is_ebreak, is_auipc, is_lui, is_jal, is_jalr;
  logic                is_load, is_store, reg_wen, dec_illegal, wb_en;

  core_fsm i_core_fsm (
    .clk, .reset,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .inst,
    .need_imm, .imm, .is_ebreak, .is_auipc, .is_lui, .is_jal, .is_jalr,
    .is_load, .is_store, .reg_wen, .illegal(dec_illegal),
    .rs1_data, .rs2_data,
    .alu_a, .alu_b, .alu_result,
    .wb_en, .wb_data,
    .halted, .illegal_halt(illegal)
  );

  decoder i_decoder (
    .inst, .rd, .rs1, .rs2, .imm, .need_imm, .alu_op,
    .is_ebreak, .is_auipc, .is_lui, .is_jal, .is_jalr, .is_load, .is_store,
    .reg_wen, .illegal(dec_illegal)
  );

  regfile i_regfile (
    .clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data,
    .wen(wb_en), .rd, .wdata(wb_data)
  );

  alu i_alu (.alu_op, .src_a(alu_a), .src_b(alu_b), .result(alu_result));

endmodule

`default_nettype wire

// ==== verif/rv_core_checker.sv ====
// rv_core_checker: assertions on the memory handshake, halt behaviour and alu op encoding.
`timescale 1ns/100ps
`default_nettype none

module rv_core_checker
  import rv_pkg::*;
(
  input logic                clk,
  input logic                reset,
  input logic                mem_req,
  input logic                mem_ack,
  input logic [XLEN-1:0]     mem_addr,
  input logic                halted,
  input logic [ALU_OP_W-1:0] alu_op
);

  // req and address hold until ack.
  req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
    else $error("mem_req or mem_addr changed before mem_ack");

  release_wait: assert property (@(posedge clk) disable iff (reset)
    !mem_req && mem_ack |=> !mem_req)  // no new req while the old ack is high.
    else $error("mem_req raised while mem_ack still high");

  halt_quiet: assert property (@(posedge clk) disable iff (reset) halted |-> !mem_req)
    else $error("mem_req raised after halt");

  alu_onehot: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(alu_op) |-> $onehot0(alu_op))
    else $error("alu_op has more than one bit set");

endmodule

// rv_core carries both the bus and the decoded alu op.
bind rv_core rv_core_checker i_rv_core_checker (
  .clk(clk), .reset(reset), .mem_req(mem_req), .mem_ack(mem_ack),
  .mem_addr(mem_addr), .halted(halted), .alu_op(alu_op)
);

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
// rv_core_tb: directed programs for the rv64i core over a handshaking memory model with random ack delay.
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
;

  localparam int          MEM_WORDS = 512;            // 4 KB of doublewords.
  localparam logic [31:0] SEED      = 32'd82286;
  localparam int          N_INSTS   = 58;             // instructions executed over all tests.
  localparam int          MARGIN    = 100;            // reset pulses and slack.
  localparam int          TIMEOUT   = N_INSTS * (2 * 8 + 2) * 2 + MARGIN;
  localparam logic [11:0] RES       = 12'h400;        // result area.
  localparam logic [11:0] DAT       = 12'h600;        // operand area.

  logic            clk       = 1'b0;
  logic            reset     = 1'b1;
  logic            mem_ack   = 1'b0;
  logic [XLEN-1:0] mem_rdata = '0;
  logic            mem_req, mem_we, halted, illegal;
  logic [XLEN-1:0] mem_addr, mem_wdata;

  logic [XLEN-1:0] mem [0:MEM_WORDS-1];
  logic [31:0]     lfsr     = SEED;
  logic            busy     = 1'b0; // request seen, ack pending.
  logic [1:0]      wait_cnt = 2'd0;
  logic [9:0]      slot;            // next instruction slot, 4 bytes each.
  int              errors   = 0;
  int              cycles   = 0;

  rv_core i_rv_core (
    .clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .halted, .illegal
  );

  always #20 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[31]};
      lfsr = lfsr_next(lfsr); // one step per bit.
    end
    return v;
  endfunction

  // memory model, four-phase slave with 0 to 3 extra wait cycles.
  always @(posedge clk) begin
    if (reset) begin
      mem_ack <= 1'b0;
      busy    <= 1'b0;
    end else if (mem_req && !mem_ack && !busy) begin
      wait_cnt <= 2'(rand_bits(2));
      busy     <= 1'b1;
    end else if (busy) begin
      if (wait_cnt == 2'd0) begin
        mem_ack <= 1'b1;
        busy    <= 1'b0;
        if (mem_we) mem[mem_addr[11:3]] = mem_wdata; // whole doubleword.
        else mem_rdata <= mem[mem_addr[11:3]];
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0;                   // release after req drops.
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: core did not halt within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [XLEN-1:0] fill_value(input logic [11:0] addr);
    return {7'h2A, addr[11:3], 16'hC0DE, 7'h15, ~addr[11:3], 16'h0F1E};
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) mem[9'(i)] = fill_value({9'(i), 3'b000});
    slot = '0; // programs start at address zero.
  endtask

  task automatic preload(input logic [11:0] addr, input logic [XLEN-1:0] value);
    mem[addr[11:3]] = value;
  endtask

  task automatic emit(input logic [31:0] w);
    if (slot[0]) mem[slot[9:1]][63:32] = w; // odd slot is the upper half.
    else mem[slot[9:1]][31:0] = w;
    slot = slot + 10'd1;
  endtask

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    inst_u w;
    w.i_fmt = '{imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    inst_u w;
    w.r_fmt = '{f7, rs2, rs1, f3, rd, OP_OP};
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
    inst_u w;
    w.u_fmt = '{imm, rd, op};
    return w;
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    inst_u w;
    w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    return w;
  endfunction

  task automatic load_to(input logic [4:0] rd, input logic [11:0] addr);
    emit(i_type(OP_LOAD, rd, F3_DWORD, 5'd0, addr)); // ld rd, addr(x0).
  endtask

  task automatic store_from(input logic [4:0] rs, input logic [11:0] addr);
    inst_u w;
    w.s_fmt = '{addr[11:5], rs, 5'd0, F3_DWORD, addr[4:0], OP_STORE};
    emit(w);
  endtask

  task automatic halt_here();
    emit(i_type(OP_SYSTEM, 5'd0, F3_ADD, 5'd0, F12_EBREAK));
  endtask

  // reset for three cycles, then run until the core halts.
  task automatic run_program();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!halted) @(negedge clk);
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] actual,
                            input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_stored(input logic [11:0] addr, input logic [XLEN-1:0] expected);
    check_word($sformatf("mem[%03h]", addr), mem[addr[11:3]], expected);
  endtask

  task automatic arith_test();
    logic [XLEN-1:0] a, b;
    logic [11:0]     imm;
    logic [XLEN-1:0] want [8];
    a   = rand_bits(64) | {1'b1, 63'd0};  // negative, so slt and sltu differ.
    b   = rand_bits(64) & {1'b0, {63{1'b1}}};
    imm = 12'(rand_bits(12));
    want[0] = a + {{52{imm[11]}}, imm};
    want[1] = a + b;
    want[2] = a - b;
    want[3] = a & b;
    want[4] = a | b;
    want[5] = a ^ b;
    want[6] = {63'd0, $signed(a) < $signed(b)};
    want[7] = {63'd0, a < b};
    fill_memory();
    preload(DAT, a);
    preload(DAT + 12'd8, b);
    load_to(5'd1, DAT);
    load_to(5'd2, DAT + 12'd8);
    emit(i_type(OP_IMM, 5'd3, F3_ADD, 5'd1, imm));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd4));
    emit(r_type(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd5));   // sub.
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd6));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd7));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd8));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd9));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_SLTU, 5'd10));
    for (int k = 0; k < 8; k++) store_from(5'(3 + k), RES + 12'(8 * k));
    halt_here();
    run_program();
    for (int k = 0; k < 8; k++) check_stored(RES + 12'(8 * k), want[k]);
  endtask

  task automatic shift_test();
    logic [XLEN-1:0] a;
    logic [17:0]     hi;                  // junk above the six shift bits.
    logic [XLEN-1:0] want [6];
    a  = rand_bits(64) | {1'b1, 63'd0};
    hi = 18'(rand_bits(18));
    want[0] = a << 5;
    want[1] = a >> 33;
    want[2] = $signed(a) >>> 47;
    want[3] = a << 36;
    want[4] = a >> 63;
    want[5] = $signed(a) >>> 32;
    fill_memory();
    preload(DAT, a);
    load_to(5'd1, DAT);
    emit(i_type(OP_IMM, 5'd3, F3_SLL, 5'd1, {6'b000000, 6'd5}));
    emit(i_type(OP_IMM, 5'd4, F3_SR, 5'd1, {6'b000000, 6'd33}));
    emit(i_type(OP_IMM, 5'd5, F3_SR, 5'd1, {6'b010000, 6'd47}));  // srai.
    emit(i_type(OP_IMM, 5'd2, F3_ADD, 5'd0, {hi[5:0], 6'd36}));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd6));
    emit(i_type(OP_IMM, 5'd2, F3_ADD, 5'd0, {hi[11:6], 6'd63}));
    emit(r_type(F7_BASE, 5'd2, 5'd1, F3_SR, 5'd7));
    emit(i_type(OP_IMM, 5'd2, F3_ADD, 5'd0, {hi[17:12], 6'd32}));
    emit(r_type(F7_ALT, 5'd2, 5'd1, F3_SR, 5'd8));
    for (int k = 0; k < 6; k++) store_from(5'(3 + k), RES + 12'(8 * k));
    halt_here();
    run_program();
    for (int k = 0; k < 6; k++) check_stored(RES + 12'(8 * k), want[k]);
  endtask

  task automatic jump_test();
    logic [19:0] u1, u2;
    u1 = 20'(rand_bits(20));
    u2 = 20'(rand_bits(20));
    fill_memory();
    emit(u_type(OP_LUI, 5'd3, u1));                  // 0x00.
    emit(u_type(OP_AUIPC, 5'd4, u2));                // 0x04.
    emit(jal_word(5'd5, 21'd8));                     // 0x08, over the next store.
    store_from(5'd3, RES + 12'd24);                  // 0x0c, never runs.
    store_from(5'd3, RES);
    store_from(5'd4, RES + 12'd8);
    store_from(5'd5, RES + 12'd16);
    emit(jal_word(5'd1, 21'd12));                    // 0x1c, call 0x28.
    store_from(5'd6, RES + 12'd32);                  // 0x20, return lands here.
    halt_here();
    emit(i_type(OP_JALR, 5'd6, F3_ADD, 5'd1, 12'd1)); // 0x28, odd target gets bit 0 cleared.
    run_program();
    check_stored(RES, {{32{u1[19]}}, u1, 12'd0});
    check_stored(RES + 12'd8, 64'd4 + {{32{u2[19]}}, u2, 12'd0});
    check_stored(RES + 12'd16, 64'd12);
    check_stored(RES + 12'd24, fill_value(RES + 12'd24));
    check_stored(RES + 12'd32, 64'd44);
  endtask

  task automatic load_use_test();
    logic [XLEN-1:0] w;
    logic [11:0]     imm;
    w   = rand_bits(64);
    imm = 12'(rand_bits(12));
    fill_memory();
    preload(DAT, w);
    load_to(5'd1, DAT);
    emit(i_type(OP_IMM, 5'd2, F3_ADD, 5'd1, imm));
    store_from(5'd2, RES);
    emit(i_type(OP_IMM, 5'd0, F3_ADD, 5'd1, 12'd5)); // writes to x0 go nowhere.
    load_to(5'd0, DAT);
    store_from(5'd0, RES + 12'd8);
    halt_here();
    run_program();
    check_stored(RES, w + {{52{imm[11]}}, imm});
    check_stored(RES + 12'd8, 64'd0);
    check_stored(DAT, w);
  endtask

  task automatic ebreak_test();
    fill_memory();
    emit(i_type(OP_IMM, 5'd1, F3_ADD, 5'd0, 12'd7));
    store_from(5'd1, RES);
    halt_here();
    store_from(5'd1, RES + 12'd8); // past the halt.
    run_program();
    check_flag("halted", halted, 1'b1);
    check_flag("illegal", illegal, 1'b0);
    check_stored(RES, 64'd7);
    check_stored(RES + 12'd8, fill_value(RES + 12'd8));
  endtask

  task automatic illegal_test();
    fill_memory();
    emit(i_type(OP_IMM, 5'd1, F3_ADD, 5'd0, 12'd9));
    emit(32'h0000_0063);           // beq x0, x0, 0.
    store_from(5'd1, RES);
    run_program();
    check_flag("halted", halted, 1'b1);
    check_flag("illegal", illegal, 1'b1);
    check_stored(RES, fill_value(RES));
  endtask

  initial begin
    arith_test();
    shift_test();
    jump_test();
    load_use_test();
    ebreak_test();
    illegal_test();
    $display("checks finished with %0d errors", errors);
    if (errors == 0) $display("Simulation completed successfully");
    else $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
common/rv_pkg.sv
hw/decoder/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/core_fsm.sv
hw/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rv_core_tb \
  -f rv_core.f -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
